//--- flist.f
+incdir+tests
verilog/core_pkg.sv
verilog/instr_decode.sv
verilog/register_file.sv
verilog/alu32.sv
verilog/exec_core.sv
tests/exec_core_tb.sv

//--- Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert
TOP       := exec_core_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv tests/*.sv tests/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/alu_model.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// ######################################
// Instruction encoding
// ######################################

function automatic word_t encode_reg(opcode_t op, sub_op_t sub, reg_idx_t rt, reg_idx_t ra,
                                     reg_idx_t rb);
  return {1'b0, op, rt, ra, rb, 5'b0, sub};
endfunction

function automatic word_t encode_imm(opcode_t op, reg_idx_t rt, reg_idx_t ra, logic [14:0] imm);
  return {1'b0, op, rt, ra, imm};
endfunction

function automatic word_t encode_movi(reg_idx_t rt, logic [19:0] imm);
  return {1'b0, OP_MOVI, rt, imm};
endfunction

function automatic word_t sign_ext15(logic [14:0] v);
  return {{17{v[14]}}, v};
endfunction

function automatic word_t zero_ext15(logic [14:0] v);
  return {17'b0, v};
endfunction

function automatic word_t sign_ext20(logic [19:0] v);
  return {{12{v[19]}}, v};
endfunction

// ######################################
// Expected result and overflow
// ######################################

function automatic word_t rotate_right(word_t a, logic [4:0] n);
  word_t r;
  r = a;
  if (n != 5'd0) begin
    r = (a >> n) | (a << (6'd32 - {1'b0, n}));
  end
  return r;
endfunction

function automatic word_t model_result(opcode_t op, sub_op_t sub, word_t a, word_t b);
  word_t r;
  r = '0;
  if (op == OP_ALU) begin
    case (sub)
      SUB_ADD:   r = a + b;
      SUB_SUB:   r = a - b;
      SUB_AND:   r = a & b;
      SUB_OR:    r = a | b;
      SUB_XOR:   r = a ^ b;
      SUB_SLLI:  r = a << b[4:0];
      SUB_SRLI:  r = a >> b[4:0];
      SUB_ROTRI: r = rotate_right(a, b[4:0]);
      default:   r = '0;
    endcase
  end else if (op == OP_ADDI) begin
    r = a + b;
  end else if (op == OP_ORI) begin
    r = a | b;
  end else if (op == OP_XORI) begin
    r = a ^ b;
  end else if (op == OP_MOVI) begin
    r = b;
  end
  return r;
endfunction

// Signed overflow means the sign of the result cannot be right for the operand signs
function automatic logic model_overflow(opcode_t op, sub_op_t sub, word_t a, word_t b);
  word_t s;
  logic  ovf;
  ovf = 1'b0;
  if (op == OP_ADDI || (op == OP_ALU && sub == SUB_ADD)) begin
    s   = a + b;
    ovf = (a[31] == b[31]) && (s[31] != a[31]);
  end else if (op == OP_ALU && sub == SUB_SUB) begin
    s   = a - b;
    ovf = (a[31] != b[31]) && (s[31] != a[31]);
  end
  return ovf;
endfunction

`endif

//--- tests/exec_core_tb.sv
`default_nettype none

module exec_core_tb import core_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 20;

  typedef struct packed {
    logic        is_illegal;
    word_t       value;
    reg_idx_t    rt;
    logic        ovf;
    logic [31:0] cycle;
  } expect_t;

  logic        clk = 1'b0;
  logic        reset;
  logic        instr_valid;
  word_t       instr;
  logic        result_valid;
  logic        overflow;
  logic        illegal;
  word_t       result;
  reg_idx_t    result_rt;

  word_t       mirror [NUM_REGS];
  expect_t     exp_q [$];
  expect_t     head;
  logic [31:0] cycle = 0;
  word_t       rng_state = 32'd47;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic        timed_out = 1'b0;
  sub_op_t     reg_subs [5] = '{SUB_ADD, SUB_SUB, SUB_AND, SUB_OR, SUB_XOR};

  `include "alu_model.svh"

  exec_core exec_core_i (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result_valid (result_valid),
    .overflow     (overflow),
    .illegal      (illegal),
    .result       (result),
    .result_rt    (result_rt)
  );

  always #10 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // ######################################
  // Output checks
  // ######################################

  // Outputs change at the rising edge, so they are sampled at the falling one
  always @(negedge clk) begin
    if (!reset && (result_valid || illegal)) begin
      checks++;
      assert (!(result_valid && illegal)) else begin
        $display("result_valid and illegal were high together at %0t", $time);
        errors++;
      end
      assert (exp_q.size() > 0) else begin
        $display("An output strobe came at %0t with no instruction pending", $time);
        errors++;
      end
      if (exp_q.size() > 0) begin
        head = exp_q.pop_front();
        assert (cycle == head.cycle + 2 && illegal == head.is_illegal) else begin
          $display("The strobe at %0t came at the wrong cycle or was of the wrong kind", $time);
          errors++;
        end
        assert (head.is_illegal || (result == head.value && result_rt == head.rt &&
                overflow == head.ovf)) else begin
          $display("Error at %0t: r%0d = %h ovf %b, expected r%0d = %h ovf %b", $time,
                   result_rt, result, overflow, head.rt, head.value, head.ovf);
          errors++;
        end
      end
    end
  end

  // ######################################
  // Stimulus
  // ######################################

  function automatic word_t rand_word();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic reg_idx_t rand_reg();
    return reg_idx_t'(rand_word());
  endfunction

  // The mirror is updated at issue, as the core finishes instructions in order
  task automatic issue(word_t word, word_t b, logic legal);
    expect_t e;
    @(posedge clk);
    #2;
    instr_valid  = 1'b1;
    instr        = word;
    e.is_illegal = ~legal;
    e.rt         = word[24:20];
    e.cycle      = cycle;
    e.value      = legal ? model_result(word[30:25], word[4:0], mirror[word[19:15]], b) : '0;
    e.ovf        = legal ? model_overflow(word[30:25], word[4:0], mirror[word[19:15]], b) : 1'b0;
    exp_q.push_back(e);
    if (legal) begin
      mirror[word[24:20]] = e.value;
    end
  endtask

  task automatic reg_op(sub_op_t sub, reg_idx_t rt, reg_idx_t ra, reg_idx_t rb);
    issue(encode_reg(OP_ALU, sub, rt, ra, rb), mirror[rb], 1'b1);
  endtask

  task automatic shift_op(sub_op_t sub, reg_idx_t rt, reg_idx_t ra, logic [4:0] amt);
    issue(encode_reg(OP_ALU, sub, rt, ra, amt), {27'b0, amt}, 1'b1);
  endtask

  task automatic imm_op(opcode_t op, reg_idx_t rt, reg_idx_t ra, logic [14:0] imm);
    issue(encode_imm(op, rt, ra, imm), op == OP_ADDI ? sign_ext15(imm) : zero_ext15(imm), 1'b1);
  endtask

  task automatic movi(reg_idx_t rt, logic [19:0] imm);
    issue(encode_movi(rt, imm), sign_ext20(imm), 1'b1);
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk);
      #2;
      instr_valid = 1'b0;
    end
  endtask

  task automatic end_test(string name, int errors_before);
    int   waited;
    logic late;
    waited = 0;
    idle(1);
    while (exp_q.size() > 0 && waited < TIMEOUT_CYCLES) begin
      idle(1);
      waited++;
    end
    late = exp_q.size() > 0;
    if (late) begin
      $display("Timeout: %0d results never appeared in test %s", exp_q.size(), name);
      timed_out = 1'b1;
      exp_q.delete();
    end
    tests_run++;
    if (errors != errors_before || late) begin
      tests_failed++;
      $display("Test %s: FAIL", name);
    end else begin
      $display("Test %s: PASS", name);
    end
  endtask

  initial begin
    int e0;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      mirror[i] = '0;
    end
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;

    e0 = errors;
    idle(10);
    end_test("idle after reset", e0);

    e0 = errors;
    for (int i = 0; i < NUM_REGS; i++) begin
      movi(reg_idx_t'(i), 20'(rand_word()));
    end
    for (int i = 0; i < 40; i++) begin
      reg_op(reg_subs[i % 5], rand_reg(), rand_reg(), rand_reg());
    end
    // A large positive word and the most negative word, built from MOVI and a shift
    movi(5'd1, 20'h7ffff);
    shift_op(SUB_SLLI, 5'd1, 5'd1, 5'd12);
    movi(5'd2, 20'h80000);
    shift_op(SUB_SLLI, 5'd2, 5'd2, 5'd12);
    reg_op(SUB_ADD, 5'd3, 5'd1, 5'd1);
    reg_op(SUB_ADD, 5'd4, 5'd2, 5'd2);
    reg_op(SUB_SUB, 5'd5, 5'd1, 5'd2);
    reg_op(SUB_SUB, 5'd6, 5'd2, 5'd1);
    end_test("register ALU ops", e0);

    e0 = errors;
    imm_op(OP_ADDI, 5'd7, 5'd2, 15'h4000);
    for (int i = 0; i < 12; i++) begin
      imm_op(OP_ADDI, rand_reg(), rand_reg(), 15'(rand_word()) | 15'h4000);
      imm_op(OP_ORI, rand_reg(), rand_reg(), 15'(rand_word()));
      imm_op(OP_XORI, rand_reg(), rand_reg(), 15'(rand_word()));
    end
    end_test("immediate ops", e0);

    e0 = errors;
    for (int i = 0; i < 32; i++) begin
      shift_op(SUB_SLLI, rand_reg(), rand_reg(), 5'(i));
      shift_op(SUB_SRLI, rand_reg(), rand_reg(), 5'(i));
      shift_op(SUB_ROTRI, rand_reg(), rand_reg(), 5'(i));
    end
    end_test("shifts and rotates", e0);

    e0 = errors;
    movi(5'd3, 20'(rand_word()));
    imm_op(OP_ADDI, 5'd3, 5'd3, 15'(rand_word()));
    reg_op(SUB_ADD, 5'd4, 5'd3, 5'd3);
    reg_op(SUB_SUB, 5'd5, 5'd4, 5'd3);
    reg_op(SUB_XOR, 5'd0, 5'd5, 5'd4);
    reg_op(SUB_OR, 5'd6, 5'd0, 5'd0);
    shift_op(SUB_ROTRI, 5'd0, 5'd0, 5'd7);
    reg_op(SUB_ADD, 5'd7, 5'd0, 5'd6);
    end_test("dependent chain", e0);

    e0 = errors;
    issue(encode_reg(6'b111111, SUB_ADD, 5'd9, 5'd1, 5'd2), '0, 1'b0);
    issue(encode_reg(6'b000000, SUB_ADD, 5'd9, 5'd1, 5'd2), '0, 1'b0);
    issue(encode_reg(6'b101001, SUB_OR, 5'd9, 5'd1, 5'd2), '0, 1'b0);
    issue(encode_reg(OP_ALU, 5'b00101, 5'd9, 5'd1, 5'd2), '0, 1'b0);
    issue(encode_reg(OP_ALU, 5'b11111, 5'd9, 5'd1, 5'd2), '0, 1'b0);
    imm_op(OP_ADDI, 5'd10, 5'd9, 15'd0);
    end_test("illegal encodings", e0);

    $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/exec_core.sv
`default_nettype none

module exec_core import core_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     instr_valid,
  input  word_t    instr,
  output logic     result_valid,
  output logic     overflow,
  output logic     illegal,
  output word_t    result,
  output reg_idx_t result_rt
);

  decoded_op_t dec;
  word_t       ra_data;
  word_t       rb_data;
  word_t       operand_b;
  word_t       alu_result;
  logic        alu_overflow;

  instr_decode instr_decode_i (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .dec         (dec)
  );

  // The write lands on the edge that ends the execute cycle
  register_file register_file_i (
    .clk     (clk),
    .reset   (reset),
    .ra_idx  (dec.ra),
    .rb_idx  (dec.rb),
    .wr_idx  (dec.rt),
    .wr_en   (dec.exec),
    .wr_data (alu_result),
    .ra_data (ra_data),
    .rb_data (rb_data)
  );

  assign operand_b = dec.use_imm ? dec.imm : rb_data;

  alu32 alu32_i (
    .scr1           (ra_data),
    .scr2           (operand_b),
    .opcode         (dec.opcode),
    .sub_opcode     (dec.sub_op),
    .enable_execute (dec.exec),
    .alu_result     (alu_result),
    .alu_overflow   (alu_overflow)
  );

  // ######################################
  // Output registers
  // ######################################

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
      illegal      <= 1'b0;
      overflow     <= 1'b0;
    end else begin
      result_valid <= dec.exec;
      illegal      <= dec.illegal;
      overflow     <= alu_overflow;
    end
  end

  always_ff @(posedge clk) begin
    result    <= alu_result;
    result_rt <= dec.rt;
  end

endmodule

`default_nettype wire

//--- verilog/alu32.sv
`default_nettype none

module alu32 import core_pkg::*; (
  input  word_t   scr1,
  input  word_t   scr2,
  input  opcode_t opcode,
  input  sub_op_t sub_opcode,
  input  logic    enable_execute,
  output word_t   alu_result,
  output logic    alu_overflow
);

  logic        is_sub;
  word_t       operand_b;
  logic [31:0] low_sum;
  logic        carry_31;
  logic [1:0]  high_sum;
  word_t       sum;
  logic        sum_overflow;
  logic [63:0] rotate;

  // ######################################
  // Shared adder
  // ######################################

  // SUB is the adder fed with the inverted operand and a carry in of one
  assign is_sub    = (opcode == OP_ALU) && (sub_opcode == SUB_SUB);
  assign operand_b = is_sub ? ~scr2 : scr2;

  // Split at bit 31 so the carry into the sign bit is visible
  assign low_sum  = {1'b0, scr1[30:0]} + {1'b0, operand_b[30:0]} + {31'b0, is_sub};
  assign carry_31 = low_sum[31];
  assign high_sum = {1'b0, scr1[31]} + {1'b0, operand_b[31]} + {1'b0, carry_31};
  assign sum      = {high_sum[0], low_sum[30:0]};

  // Signed overflow when the carries into and out of the sign bit differ
  assign sum_overflow = carry_31 ^ high_sum[1];

  assign rotate = {scr1, scr1} >> scr2[4:0];

  // ######################################
  // Result select
  // ######################################

  always_comb begin
    alu_result   = '0;
    alu_overflow = 1'b0;
    if (enable_execute) begin
      case (opcode)
        OP_ALU: begin
          case (sub_opcode)
            SUB_ADD, SUB_SUB: begin
              alu_result   = sum;
              alu_overflow = sum_overflow;
            end
            SUB_AND: begin
              alu_result = scr1 & scr2;
            end
            SUB_OR: begin
              alu_result = scr1 | scr2;
            end
            SUB_XOR: begin
              alu_result = scr1 ^ scr2;
            end
            SUB_SLLI: begin
              alu_result = scr1 << scr2;
            end
            SUB_SRLI: begin
              alu_result = scr1 >> scr2;
            end
            SUB_ROTRI: begin
              alu_result = rotate[31:0];
            end
            default: begin
              alu_result = '0;
            end
          endcase
        end
        OP_ADDI: begin
          alu_result   = sum;
          alu_overflow = sum_overflow;
        end
        OP_ORI: begin
          alu_result = scr1 | scr2;
        end
        OP_XORI: begin
          alu_result = scr1 ^ scr2;
        end
        // MOVI passes the immediate straight through
        OP_MOVI: begin
          alu_result = scr2;
        end
        default: begin
          alu_result = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`default_nettype none

module register_file import core_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t ra_idx,
  input  reg_idx_t rb_idx,
  input  reg_idx_t wr_idx,
  input  logic     wr_en,
  input  word_t    wr_data,
  output word_t    ra_data,
  output word_t    rb_data
);

  word_t regs [NUM_REGS];

  // ######################################
  // Write port
  // ######################################

  // Register 0 is plain storage and is not tied to zero
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // ######################################
  // Read ports
  // ######################################

  // Reads are combinational, so a value written at an edge is seen by the
  // instruction decoded at that same edge
  assign ra_data = regs[ra_idx];
  assign rb_data = regs[rb_idx];

endmodule

`default_nettype wire

//--- verilog/instr_decode.sv
`default_nettype none

module instr_decode import core_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        instr_valid,
  input  word_t       instr,
  output decoded_op_t dec
);

  opcode_t opcode;
  sub_op_t sub_op;
  logic    legal;
  logic    use_imm;
  word_t   imm;

  assign opcode = instr[30:25];
  assign sub_op = instr[4:0];

  // Immediate forms and the legality check both hang on the major opcode
  always_comb begin
    legal   = 1'b0;
    use_imm = 1'b0;
    imm     = '0;
    case (opcode)
      OP_ALU: begin
        imm = {27'b0, instr[14:10]};
        case (sub_op)
          SUB_ADD, SUB_SUB, SUB_AND, SUB_XOR, SUB_OR: begin
            legal = 1'b1;
          end
          SUB_SLLI, SUB_SRLI, SUB_ROTRI: begin
            legal   = 1'b1;
            use_imm = 1'b1;
          end
          default: begin
            legal = 1'b0;
          end
        endcase
      end
      OP_ADDI: begin
        legal   = 1'b1;
        use_imm = 1'b1;
        imm     = {{17{instr[14]}}, instr[14:0]};
      end
      OP_ORI, OP_XORI: begin
        legal   = 1'b1;
        use_imm = 1'b1;
        imm     = {17'b0, instr[14:0]};
      end
      OP_MOVI: begin
        legal   = 1'b1;
        use_imm = 1'b1;
        imm     = {{12{instr[19]}}, instr[19:0]};
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dec <= '0;
    end else begin
      dec.exec    <= instr_valid & legal;
      dec.illegal <= instr_valid & ~legal;
      dec.opcode  <= opcode;
      dec.sub_op  <= sub_op;
      dec.rt      <= instr[24:20];
      dec.ra      <= instr[19:15];
      dec.rb      <= instr[14:10];
      dec.use_imm <= use_imm;
      dec.imm     <= imm;
    end
  end

endmodule

`default_nettype wire

//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

  // ######################################
  // Widths with a meaning
  // ######################################

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [4:0]  sub_op_t;

  localparam int NUM_REGS = 32;

  // Major opcodes taken from instruction bits 30 to 25
  localparam opcode_t OP_ALU  = 6'b100000;
  localparam opcode_t OP_ADDI = 6'b101000;
  localparam opcode_t OP_ORI  = 6'b101100;
  localparam opcode_t OP_XORI = 6'b101011;
  localparam opcode_t OP_MOVI = 6'b100010;

  // ALU sub-opcodes in bits 4 to 0 of an OP_ALU word
  localparam sub_op_t SUB_ADD   = 5'b00000;
  localparam sub_op_t SUB_SUB   = 5'b00001;
  localparam sub_op_t SUB_AND   = 5'b00010;
  localparam sub_op_t SUB_XOR   = 5'b00011;
  localparam sub_op_t SUB_OR    = 5'b00100;
  localparam sub_op_t SUB_SLLI  = 5'b01000;
  localparam sub_op_t SUB_SRLI  = 5'b01001;
  localparam sub_op_t SUB_ROTRI = 5'b01011;

  // ######################################
  // Decoded instruction
  // ######################################

  // One instruction as it sits in the execute stage
  typedef struct packed {
    logic     exec;
    logic     illegal;
    opcode_t  opcode;
    sub_op_t  sub_op;
    reg_idx_t rt;
    reg_idx_t ra;
    reg_idx_t rb;
    logic     use_imm;
    word_t    imm;
  } decoded_op_t;

endpackage

`default_nettype wire
